/* project.f */
+incdir+source
source/serial_pkg.sv
source/serial_regs.sv
source/serial_state.sv
source/serial_alu.sv
source/serial_bufreg.sv
source/serial_top.sv
testbench/serial_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f project.f --top-module serial_tb \
   --Mdir obj_dir -o serial_sim \
   && ./obj_dir/serial_sim | tee sim.log \
   || { echo "build or run of the simulation failed"; exit 1; }

grep -qx "ALL CHECKS PASSED" sim.log \
   && { echo "simulation result: pass"; exit 0; } \
   || { echo "simulation result: fail"; exit 1; }

/* source/serial_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module serial_alu (
   input  logic            i_clk,
   input  logic            i_rst,
   input  serial_pkg::op_e i_op,
   input  logic            i_cnt_en,
   input  logic            i_cnt0,
   input  logic            i_init,
   input  logic            i_opa_bit,
   input  logic            i_opb_bit,
   output logic            o_res_bit
);

   logic is_cmp;
   logic is_sub;
   logic b_eff;
   logic c_in;
   logic c_out;
   logic sum_bit;
   logic cmp_now;
   logic carry_r;
   logic cmp_r;

   assign is_cmp = (i_op == serial_pkg::OP_SLT) | (i_op == serial_pkg::OP_SLTU);

   // compares are computed as a subtraction a - b
   assign is_sub = (i_op == serial_pkg::OP_SUB) | is_cmp;

   // subtraction adds the inverted b with a carry in of one at bit 0
   assign b_eff = i_opb_bit ^ is_sub;
   assign c_in  = i_cnt0 ? is_sub : carry_r;

   assign sum_bit = i_opa_bit ^ b_eff ^ c_in;
   assign c_out   = (i_opa_bit & b_eff) | (c_in & (i_opa_bit ^ b_eff));

   // unsigned a < b exactly when the subtraction borrows out of bit 31
   // signed with differing signs depends on the sign of a alone
   // and with equal signs the difference sign decides
   assign cmp_now = (i_op == serial_pkg::OP_SLTU) ? !c_out :
                    ((i_opa_bit ^ i_opb_bit) ? i_opa_bit : sum_bit);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_r <= 1'b0;
         cmp_r   <= 1'b0;
      end else if (i_cnt_en) begin
         carry_r <= c_out;
         // updated every init cycle so the bit 31 value remains after the pass
         if (i_init) begin
            cmp_r <= cmp_now;
         end
      end
   end

   always_comb begin
      case (i_op)
         serial_pkg::OP_AND:  o_res_bit = i_opa_bit & i_opb_bit;
         serial_pkg::OP_XOR:  o_res_bit = i_opa_bit ^ i_opb_bit;
         // the flag lands in bit 0 and the remaining bits are zero
         serial_pkg::OP_SLT:  o_res_bit = i_cnt0 & cmp_r;
         serial_pkg::OP_SLTU: o_res_bit = i_cnt0 & cmp_r;
         default:             o_res_bit = sum_bit;
      endcase
   end

endmodule

`default_nettype wire

/* source/serial_bufreg.sv */
`timescale 1ns/10ps
`default_nettype none
`include "serial_config.svh"

module serial_bufreg (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_load,
   input  logic                  i_cnt_en,
   input  logic                  i_wr_en,
   input  logic [`SERIAL_DW-1:0] i_opa,
   input  logic [`SERIAL_DW-1:0] i_opb,
   input  logic                  i_res_bit,
   output logic                  o_opa_bit,
   output logic                  o_opb_bit,
   output logic [`SERIAL_DW-1:0] o_result
);

   logic [`SERIAL_DW-1:0] opa_r;
   logic [`SERIAL_DW-1:0] opb_r;
   logic [`SERIAL_DW-1:0] res_r;

   // operand bits leave from the bottom, least significant first
   assign o_opa_bit = opa_r[0];
   assign o_opb_bit = opb_r[0];

   assign o_result = res_r;

   // the operands rotate instead of shifting out
   // so after a full 32 cycle pass they are back in place for the next one
   always_ff @(posedge i_clk) begin
      if (i_load) begin
         opa_r <= i_opa;
         opb_r <= i_opb;
      end else if (i_cnt_en) begin
         opa_r <= {opa_r[0], opa_r[`SERIAL_DW-1:1]};
         opb_r <= {opb_r[0], opb_r[`SERIAL_DW-1:1]};
      end
   end

   // result bits enter at the top and walk down
   // after 32 writes the first bit produced sits in bit 0
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         res_r <= '0;
      end else if (i_wr_en) begin
         res_r <= {i_res_bit, res_r[`SERIAL_DW-1:1]};
      end
   end

   // a load in the middle of a pass would corrupt the rotation
   assert property (@(posedge i_clk) disable iff (i_rst)
      i_load |-> !i_cnt_en);

endmodule

`default_nettype wire

/* source/serial_config.svh */
`ifndef SERIAL_CONFIG_SVH
`define SERIAL_CONFIG_SVH

// apb byte address width of the register window
`define SERIAL_AW 5

// operand and result width
// the split counter covers exactly 32 bit positions so this cannot change
`define SERIAL_DW 32

// register byte offsets inside the apb window
`define SERIAL_REG_OPA    5'h00
`define SERIAL_REG_OPB    5'h04
`define SERIAL_REG_CTRL   5'h08
`define SERIAL_REG_STATUS 5'h0C
`define SERIAL_REG_RESULT 5'h10

// the op field occupies the low bits of the control register
`define SERIAL_CTRL_OP_MSB 2

// writing a one here launches a job when the unit is idle
`define SERIAL_CTRL_START_BIT 8

`endif

/* source/serial_pkg.sv */
`default_nettype none

package serial_pkg;

   // operation codes as written into the low bits of the control register
   // the first four finish in a single pass over the operands
   // the two compares need an init pass before the result is written
   typedef enum logic [2:0] {
      // a + b
      OP_ADD  = 3'd0,
      // a - b
      OP_SUB  = 3'd1,
      // bitwise and
      OP_AND  = 3'd2,
      // bitwise xor
      OP_XOR  = 3'd3,
      // set to one when a < b as signed numbers
      OP_SLT  = 3'd4,
      // set to one when a < b as unsigned numbers
      OP_SLTU = 3'd5
   } op_e;

   // status register bit positions
   // busy stays high from the start strobe until the result is latched
   localparam int STAT_BUSY = 0;

   // done is sticky and is cleared by writing a one to it
   localparam int STAT_DONE = 1;

endpackage

`default_nettype wire

/* source/serial_regs.sv */
`timescale 1ns/10ps
`default_nettype none
`include "serial_config.svh"

module serial_regs (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_psel,
   input  logic                  i_penable,
   input  logic                  i_pwrite,
   input  logic [`SERIAL_AW-1:0] i_paddr,
   input  logic [`SERIAL_DW-1:0] i_pwdata,
   output logic [`SERIAL_DW-1:0] o_prdata,
   output logic                  o_pready,
   output logic                  o_pslverr,
   output logic                  o_start,
   output serial_pkg::op_e       o_op,
   output logic [`SERIAL_DW-1:0] o_opa,
   output logic [`SERIAL_DW-1:0] o_opb,
   input  logic                  i_busy,
   input  logic                  i_done,
   input  logic [`SERIAL_DW-1:0] i_result,
   output logic                  o_irq
);

   logic                  access;
   logic                  wr_ok;
   logic                  sel_opa;
   logic                  sel_opb;
   logic                  sel_ctrl;
   logic                  sel_status;
   logic                  sel_result;
   logic                  mapped;
   logic                  locked;
   logic                  busy_any;
   logic                  done_r;
   logic [`SERIAL_DW-1:0] result_r;
   logic [`SERIAL_DW-1:0] ctrl_word;
   logic [`SERIAL_DW-1:0] status_word;

   // a transfer completes in the access phase and there are no wait states
   assign access   = i_psel & i_penable;
   assign o_pready = 1'b1;

   assign sel_opa    = (i_paddr == `SERIAL_REG_OPA);
   assign sel_opb    = (i_paddr == `SERIAL_REG_OPB);
   assign sel_ctrl   = (i_paddr == `SERIAL_REG_CTRL);
   assign sel_status = (i_paddr == `SERIAL_REG_STATUS);
   assign sel_result = (i_paddr == `SERIAL_REG_RESULT);
   assign mapped     = sel_opa | sel_opb | sel_ctrl | sel_status | sel_result;

   // the sequencer raises busy one cycle after the start strobe
   // so the strobe cycle itself counts as busy here
   assign busy_any = i_busy | o_start;

   // operands and control must not move under a running job
   assign locked = sel_opa | sel_opb | sel_ctrl;

   assign o_pslverr = access & (!mapped | (i_pwrite & busy_any & locked));

   // any write that is not rejected takes effect at the end of the access phase
   assign wr_ok = access & i_pwrite & !o_pslverr;

   assign o_irq = done_r;

   always_ff @(posedge i_clk) begin
      if (wr_ok && sel_opa) begin
         o_opa <= i_pwdata;
      end
      if (wr_ok && sel_opb) begin
         o_opb <= i_pwdata;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_op     <= serial_pkg::OP_ADD;
         o_start  <= 1'b0;
         done_r   <= 1'b0;
         result_r <= '0;
      end else begin
         if (wr_ok && sel_ctrl) begin
            o_op <= serial_pkg::op_e'(i_pwdata[`SERIAL_CTRL_OP_MSB:0]);
         end
         // start is a single cycle strobe and the op updates on the same edge
         o_start <= wr_ok & sel_ctrl & i_pwdata[`SERIAL_CTRL_START_BIT];
         // a finishing job wins over a clear in the same cycle
         if (i_done) begin
            done_r <= 1'b1;
         end else if (wr_ok && sel_status && i_pwdata[serial_pkg::STAT_DONE]) begin
            done_r <= 1'b0;
         end
         // the buffer holds the final result in the done cycle
         if (i_done) begin
            result_r <= i_result;
         end
      end
   end

   always_comb begin
      ctrl_word = '0;
      ctrl_word[`SERIAL_CTRL_OP_MSB:0] = o_op;
      status_word = '0;
      status_word[serial_pkg::STAT_BUSY] = busy_any;
      status_word[serial_pkg::STAT_DONE] = done_r;
   end

   // read data is only driven during a read access and is zero otherwise
   always_comb begin
      o_prdata = '0;
      if (access && !i_pwrite) begin
         case (i_paddr)
            `SERIAL_REG_OPA:    o_prdata = o_opa;
            `SERIAL_REG_OPB:    o_prdata = o_opb;
            `SERIAL_REG_CTRL:   o_prdata = ctrl_word;
            `SERIAL_REG_STATUS: o_prdata = status_word;
            `SERIAL_REG_RESULT: o_prdata = result_r;
            default:            o_prdata = '0;
         endcase
      end
   end

   // a done strobe only ever arrives for a job that the sequencer still runs
   assert property (@(posedge i_clk) disable iff (i_rst)
      i_done |-> i_busy);

   // a new job must never be launched over one that the sequencer still runs
   assert property (@(posedge i_clk) disable iff (i_rst)
      o_start |-> !i_busy);

endmodule

`default_nettype wire

/* source/serial_state.sv */
`timescale 1ns/10ps
`default_nettype none

module serial_state (
   input  logic            i_clk,
   input  logic            i_rst,
   input  logic            i_start,
   input  serial_pkg::op_e i_op,
   output logic            o_busy,
   output logic            o_load,
   output logic            o_cnt_en,
   output logic            o_cnt0,
   output logic            o_init,
   output logic            o_wr_en,
   output logic            o_done
);

   // bit position is cnt_hi * 4 plus the index of the set bit in cnt_ring
   logic [2:0] cnt_hi;
   logic [3:0] cnt_ring;
   logic       cnt_done;
   logic       init_done;
   logic       stage_two_req;
   logic       two_stage_op;
   logic       kick;

   // compares need the whole word before the result bit is known
   assign two_stage_op = (i_op == serial_pkg::OP_SLT) | (i_op == serial_pkg::OP_SLTU);

   // the ring is zero whenever the unit sits idle
   assign o_cnt_en = |cnt_ring;

   assign o_cnt0 = (cnt_hi == 3'd0) & cnt_ring[0];

   // the operands are captured in the strobe cycle right before counting begins
   assign o_load = i_start;

   // first pass of a compare only evaluates and writes nothing
   assign o_init = two_stage_op & !init_done;

   assign o_wr_en = o_cnt_en & !o_init;

   // either a fresh job or the second pass of a compare starts the ring
   assign kick = (i_start | stage_two_req) & !o_cnt_en;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         cnt_hi        <= 3'd0;
         cnt_ring      <= 4'b0000;
         cnt_done      <= 1'b0;
         init_done     <= 1'b0;
         stage_two_req <= 1'b0;
         o_done        <= 1'b0;
         o_busy        <= 1'b0;
      end else begin
         // the upper part steps each time the ring passes its last bit
         // and wraps back to zero after position 31
         cnt_hi <= cnt_hi + {2'd0, cnt_ring[3]};

         // cnt_done blocks the bit that would wrap into the ring
         // so counting stops after exactly 32 cycles
         cnt_ring <= {cnt_ring[2:0], (cnt_ring[3] & !cnt_done) | kick};

         // looking at position 30 makes this high during position 31
         cnt_done <= (cnt_hi == 3'd7) & cnt_ring[2];

         // init_done toggles on at the end of an init pass and off after the write pass
         if (cnt_done) begin
            init_done <= o_init & !init_done;
         end

         // one idle cycle separates the init pass from the write pass
         stage_two_req <= cnt_done & o_init;

         // the result is complete once the final pass has ended
         o_done <= cnt_done & !o_init;

         if (i_start) begin
            o_busy <= 1'b1;
         end else if (o_done) begin
            o_busy <= 1'b0;
         end
      end
   end

   // the end of a pass is only ever flagged while the ring is running
   assert property (@(posedge i_clk) disable iff (i_rst)
      cnt_done |-> o_cnt_en);

   // done follows the last counting cycle and must not overlap a pass
   assert property (@(posedge i_clk) disable iff (i_rst)
      o_done |-> !o_cnt_en);

endmodule

`default_nettype wire

/* source/serial_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "serial_config.svh"

module serial_top (
   input  logic                  i_clk,
   input  logic                  i_rst,
   input  logic                  i_psel,
   input  logic                  i_penable,
   input  logic                  i_pwrite,
   input  logic [`SERIAL_AW-1:0] i_paddr,
   input  logic [`SERIAL_DW-1:0] i_pwdata,
   output logic [`SERIAL_DW-1:0] o_prdata,
   output logic                  o_pready,
   output logic                  o_pslverr,
   output logic                  o_irq
);

   // register block to sequencer and buffer
   logic                  start;
   serial_pkg::op_e       op;
   logic [`SERIAL_DW-1:0] opa;
   logic [`SERIAL_DW-1:0] opb;

   // sequencer controls
   logic                  busy;
   logic                  load;
   logic                  cnt_en;
   logic                  cnt0;
   logic                  init;
   logic                  wr_en;
   logic                  done;

   // serial data between buffer and alu
   logic                  opa_bit;
   logic                  opb_bit;
   logic                  res_bit;
   logic [`SERIAL_DW-1:0] result;

   serial_regs serial_regs_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .o_pslverr (o_pslverr),
      .o_start   (start),
      .o_op      (op),
      .o_opa     (opa),
      .o_opb     (opb),
      .i_busy    (busy),
      .i_done    (done),
      .i_result  (result),
      .o_irq     (o_irq)
   );

   serial_state serial_state_inst (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_start  (start),
      .i_op     (op),
      .o_busy   (busy),
      .o_load   (load),
      .o_cnt_en (cnt_en),
      .o_cnt0   (cnt0),
      .o_init   (init),
      .o_wr_en  (wr_en),
      .o_done   (done)
   );

   serial_alu serial_alu_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_op      (op),
      .i_cnt_en  (cnt_en),
      .i_cnt0    (cnt0),
      .i_init    (init),
      .i_opa_bit (opa_bit),
      .i_opb_bit (opb_bit),
      .o_res_bit (res_bit)
   );

   serial_bufreg serial_bufreg_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_load    (load),
      .i_cnt_en  (cnt_en),
      .i_wr_en   (wr_en),
      .i_opa     (opa),
      .i_opb     (opb),
      .i_res_bit (res_bit),
      .o_opa_bit (opa_bit),
      .o_opb_bit (opb_bit),
      .o_result  (result)
   );

endmodule

`default_nettype wire

/* testbench/serial_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "serial_config.svh"

module serial_tb;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DELAY = 10;
   localparam int NUM_JOBS    = 200;
   // on average a job with its status polling stays below this
   localparam int JOB_CYCLES  = 80;
   // reset, the directed tests and the status traffic around each job
   localparam int MARGIN_CYCLES = 4000;
   localparam int POLL_LIMIT  = 100;

   logic                  i_clk;
   logic                  i_rst;
   logic                  i_psel;
   logic                  i_penable;
   logic                  i_pwrite;
   logic [`SERIAL_AW-1:0] i_paddr;
   logic [`SERIAL_DW-1:0] i_pwdata;
   logic [`SERIAL_DW-1:0] o_prdata;
   logic                  o_pready;
   logic                  o_pslverr;
   logic                  o_irq;

   logic [31:0] lfsr_state;
   int          errors;
   int          checks;

   serial_top serial_top_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .o_pslverr (o_pslverr),
      .o_irq     (o_irq)
   );

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   // fibonacci lfsr with taps 32, 22, 2 and 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // the generator advances once for every bit handed out
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] value;
      int          i;
      value = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // half of the operands are corner values around zero and the sign boundary
   function automatic logic [31:0] pick_operand();
      logic [31:0] sel;
      sel = rand_bits(3);
      case (sel)
         32'd0:   return 32'h0000_0000;
         32'd1:   return 32'hffff_ffff;
         32'd2:   return 32'h8000_0000;
         32'd3:   return 32'h7fff_ffff;
         default: return rand_bits(32);
      endcase
   endfunction

   // reference results in ordinary 32 bit arithmetic
   function automatic logic [31:0] model_result(input serial_pkg::op_e op,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
      case (op)
         serial_pkg::OP_ADD:  return a + b;
         serial_pkg::OP_SUB:  return a - b;
         serial_pkg::OP_AND:  return a & b;
         serial_pkg::OP_XOR:  return a ^ b;
         serial_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         serial_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
         default:             return 32'd0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   // enters and leaves 10 ns after a rising edge, setup then access phase
   // read data and the error flag are sampled in the middle of the access cycle
   task automatic apb_access(input logic write, input logic [`SERIAL_AW-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = write;
      i_paddr   = addr;
      i_pwdata  = wdata;
      @(posedge i_clk);
      #DRIVE_DELAY;
      i_penable = 1'b1;
      #(CLK_PERIOD / 2);
      rdata = o_prdata;
      err   = o_pslverr;
      check_value("o_pready", 32'd1, {31'd0, o_pready});
      @(posedge i_clk);
      #DRIVE_DELAY;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [`SERIAL_AW-1:0] addr, input logic [31:0] data,
                            output logic err);
      logic [31:0] unused_rdata;
      apb_access(1'b1, addr, data, unused_rdata, err);
   endtask

   task automatic apb_read(input logic [`SERIAL_AW-1:0] addr, output logic [31:0] data,
                           output logic err);
      apb_access(1'b0, addr, 32'd0, data, err);
   endtask

   task automatic wait_done();
      logic [31:0] rdata;
      logic        err;
      int          polls;
      polls = 0;
      rdata = '0;
      while (!rdata[serial_pkg::STAT_DONE] && polls < POLL_LIMIT) begin
         apb_read(`SERIAL_REG_STATUS, rdata, err);
         polls++;
      end
      if (!rdata[serial_pkg::STAT_DONE]) begin
         errors++;
         $display("status done did not come up within %0d polls at time %0t", polls, $time);
      end
   endtask

   // a disturbed job also tries to overwrite operand and control while busy
   task automatic run_job(input serial_pkg::op_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic disturb);
      logic [31:0] rdata;
      logic [31:0] start_word;
      logic        err;
      start_word = (32'd1 << `SERIAL_CTRL_START_BIT) | {29'd0, op};
      apb_write(`SERIAL_REG_OPA, a, err);
      check_value("o_pslverr opa write", 32'd0, {31'd0, err});
      apb_write(`SERIAL_REG_OPB, b, err);
      check_value("o_pslverr opb write", 32'd0, {31'd0, err});
      apb_write(`SERIAL_REG_CTRL, start_word, err);
      check_value("o_pslverr ctrl write", 32'd0, {31'd0, err});
      if (disturb) begin
         apb_write(`SERIAL_REG_OPA, ~a, err);
         check_value("o_pslverr opa write busy", 32'd1, {31'd0, err});
         apb_write(`SERIAL_REG_CTRL, start_word ^ 32'd1, err);
         check_value("o_pslverr ctrl write busy", 32'd1, {31'd0, err});
         apb_read(`SERIAL_REG_STATUS, rdata, err);
         check_value("status busy", 32'd1, {31'd0, rdata[serial_pkg::STAT_BUSY]});
      end
      wait_done();
      check_value("o_irq after done", 32'd1, {31'd0, o_irq});
      apb_read(`SERIAL_REG_STATUS, rdata, err);
      check_value("status after done", 32'd1 << serial_pkg::STAT_DONE, rdata);
      apb_read(`SERIAL_REG_RESULT, rdata, err);
      check_value("result", model_result(op, a, b), rdata);
      if (disturb) begin
         apb_read(`SERIAL_REG_OPA, rdata, err);
         check_value("opa after busy write", a, rdata);
         apb_read(`SERIAL_REG_CTRL, rdata, err);
         check_value("ctrl after busy write", {29'd0, op}, rdata);
      end
      // writing one to the done bit clears the sticky flag and the interrupt
      apb_write(`SERIAL_REG_STATUS, 32'd1 << serial_pkg::STAT_DONE, err);
      check_value("o_irq after clear", 32'd0, {31'd0, o_irq});
      apb_read(`SERIAL_REG_STATUS, rdata, err);
      check_value("status after clear", 32'd0, rdata);
   endtask

   initial begin
      logic [31:0]     rdata;
      logic [31:0]     a;
      logic [31:0]     b;
      logic            err;
      serial_pkg::op_e op;
      int              job;
      lfsr_state = 32'h9d10_7ba1;
      errors     = 0;
      checks     = 0;
      i_rst      = 1'b1;
      i_psel     = 1'b0;
      i_penable  = 1'b0;
      i_pwrite   = 1'b0;
      i_paddr    = '0;
      i_pwdata   = '0;
      repeat (2) @(posedge i_clk);
      #DRIVE_DELAY;
      i_rst = 1'b0;

      // everything comes out of reset idle and cleared
      check_value("o_irq after reset", 32'd0, {31'd0, o_irq});
      check_value("o_pslverr after reset", 32'd0, {31'd0, o_pslverr});
      apb_read(`SERIAL_REG_STATUS, rdata, err);
      check_value("status after reset", 32'd0, rdata);
      apb_read(`SERIAL_REG_RESULT, rdata, err);
      check_value("result after reset", 32'd0, rdata);

      for (job = 0; job < NUM_JOBS; job++) begin
         a  = pick_operand();
         b  = pick_operand();
         op = serial_pkg::op_e'(3'(rand_bits(3) % 6));
         run_job(op, a, b, (job % 16) == 3);
      end

      // unmapped offsets answer with an error and leave the registers alone
      apb_write(`SERIAL_REG_OPA, 32'h1234_5678, err);
      apb_write(`SERIAL_REG_OPB, 32'h9abc_def0, err);
      apb_write(`SERIAL_REG_CTRL, {29'd0, serial_pkg::OP_SUB}, err);
      apb_write(5'h14, 32'hffff_ffff, err);
      check_value("o_pslverr write 0x14", 32'd1, {31'd0, err});
      apb_write(5'h02, 32'hffff_ffff, err);
      check_value("o_pslverr write 0x02", 32'd1, {31'd0, err});
      apb_read(5'h1C, rdata, err);
      check_value("o_pslverr read 0x1c", 32'd1, {31'd0, err});
      apb_read(`SERIAL_REG_OPA, rdata, err);
      check_value("opa after unmapped", 32'h1234_5678, rdata);
      apb_read(`SERIAL_REG_OPB, rdata, err);
      check_value("opb after unmapped", 32'h9abc_def0, rdata);
      apb_read(`SERIAL_REG_CTRL, rdata, err);
      check_value("ctrl after unmapped", {29'd0, serial_pkg::OP_SUB}, rdata);

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // bounds the run in case the unit never reports done
   initial begin
      #((NUM_JOBS * JOB_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("timeout after %0d cycles, the test sequence did not finish",
               NUM_JOBS * JOB_CYCLES + MARGIN_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
